// File: rtl/sdr_pkg.sv
// shared constants for the boot-time sector loader
// address map of the SD block controller, sector geometry and status bit positions
// referenced by scoped names from the RTL and the testbench

`default_nettype none

package sdr_pkg;

    // bytes held by one SD sector
    parameter int SECTOR_BYTES = 512;

    // APB bus geometry between the reader and the controller
    parameter int APB_AW = 16;
    parameter int APB_DW = 32;

    // controller address map
    // a write to the command register starts a fetch of the written sector number
    parameter logic [15:0] CMD_ADDR = 16'h0000;

    // read-only status word
    parameter logic [15:0] STATUS_ADDR = 16'h0004;

    // buffer byte i is read at BUF_BASE + i
    parameter logic [15:0] BUF_BASE = 16'h1000;

    // status word fields
    // busy is high while the card transfer runs
    parameter int STAT_BUSY = 0;

    // ready is high once a whole sector sits in the buffer
    parameter int STAT_READY = 1;

endpackage

`default_nettype wire

// File: rtl/sector_buffer.sv
// one-sector byte store between the card port and the APB read path
// registered write, combinational read; can be swapped for a block RAM

`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
    input  wire        clk,
    input  wire        we,
    input  wire  [8:0] waddr,
    input  wire  [7:0] wdata,
    input  wire  [8:0] raddr,
    output logic [7:0] rdata
);

    logic [7:0] mem [0:sdr_pkg::SECTOR_BYTES-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port sees the array directly
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: rtl/sd_block_ctrl.sv
// APB slave front end of the SD block controller
// a command write requests a sector from the card port and fills the sector buffer;
// status and buffer bytes are read back over APB with zero wait states

`timescale 1ns/1ps
`default_nettype none

module sd_block_ctrl (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [sdr_pkg::APB_AW-1:0]    paddr,
    input  wire  [sdr_pkg::APB_DW-1:0]    pwdata,
    output logic [sdr_pkg::APB_DW-1:0]    prdata,
    output logic                          pready,
    output logic                          card_req,
    output logic [31:0]                   card_sector,
    input  wire                           card_valid,
    input  wire  [7:0]                    card_data,
    output logic                          buf_we,
    output logic [8:0]                    buf_waddr,
    output logic [7:0]                    buf_wdata,
    output logic [8:0]                    buf_raddr,
    input  wire  [7:0]                    buf_rdata
);

    logic                       busy;
    logic                       ready;
    logic [8:0]                 widx;
    logic                       access;
    logic                       cmd_write;
    logic                       in_buf_range;
    logic [sdr_pkg::APB_AW-1:0] buf_offset;

    // every transfer completes in its first access cycle
    assign access = psel && penable;
    assign pready = access;

    assign cmd_write = access && pwrite && (paddr == sdr_pkg::CMD_ADDR);

    assign buf_offset   = paddr - sdr_pkg::BUF_BASE;
    assign in_buf_range = (paddr >= sdr_pkg::BUF_BASE) &&
                          (buf_offset < 16'(sdr_pkg::SECTOR_BYTES));
    assign buf_raddr    = buf_offset[8:0];

    always_comb begin
        prdata = '0;
        if (paddr == sdr_pkg::STATUS_ADDR) begin
            prdata[sdr_pkg::STAT_BUSY]  = busy;
            prdata[sdr_pkg::STAT_READY] = ready;
        end else if (in_buf_range) begin
            prdata[7:0] = buf_rdata;
        end
    end

    // card bytes land in the buffer in arrival order
    assign buf_we    = busy && card_valid;
    assign buf_waddr = widx;
    assign buf_wdata = card_data;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy     <= 1'b0;
            ready    <= 1'b0;
            card_req <= 1'b0;
            widx     <= '0;
        end else begin
            card_req <= 1'b0;
            if (cmd_write && !busy) begin
                busy     <= 1'b1;
                ready    <= 1'b0;
                card_req <= 1'b1;
                widx     <= '0;
            end else if (buf_we) begin
                widx <= widx + 9'd1;
                if (widx == 9'(sdr_pkg::SECTOR_BYTES - 1)) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    // sector number goes out with the request pulse
    always_ff @(posedge clk) begin
        if (cmd_write && !busy) begin
            card_sector <= pwdata;
        end
    end

    // the card only streams in answer to a request
    a_card_when_busy: assert property (@(posedge clk) disable iff (!rstn)
        card_valid |-> busy);

endmodule

`default_nettype wire

// File: rtl/sector_reader.sv
// APB master that reads one SD sector through the block controller
// writes the sector number, polls status, then streams the 512 buffer bytes out
// one byte per APB read; a high hold stalls the next buffer read

`timescale 1ns/1ps
`default_nettype none

module sector_reader (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           start,
    input  wire [31:0]                    sector,
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [sdr_pkg::APB_AW-1:0]    paddr,
    output logic [sdr_pkg::APB_DW-1:0]    pwdata,
    input  wire  [sdr_pkg::APB_DW-1:0]    prdata,
    input  wire                           pready,
    output logic                          out_valid,
    output logic [8:0]                    out_index,
    output logic [7:0]                    out_byte,
    input  wire                           hold,
    output logic                          done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_POLL,
        S_WAIT_HOLD,
        S_FETCH,
        S_EMIT,
        S_FINISHED,
        S_REARM
    } state_t;

    state_t state;

    // one bit wider than the buffer index so it can reach SECTOR_BYTES
    logic [9:0] count;

    logic       last_byte;

    assign last_byte = (count == 10'(sdr_pkg::SECTOR_BYTES));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_IDLE;
            psel      <= 1'b0;
            penable   <= 1'b0;
            pwrite    <= 1'b0;
            count     <= '0;
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        // setup phase of the command write
                        psel   <= 1'b1;
                        pwrite <= 1'b1;
                        paddr  <= sdr_pkg::CMD_ADDR;
                        pwdata <= sector;
                        count  <= '0;
                        state  <= S_CMD;
                    end
                end
                S_CMD: begin
                    if (!penable) begin
                        penable <= 1'b1;
                    end else if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        pwrite  <= 1'b0;
                        state   <= S_POLL;
                    end
                end
                S_POLL: begin
                    // each pass is a full status read, repeated until the sector is in
                    if (!psel) begin
                        psel  <= 1'b1;
                        paddr <= sdr_pkg::STATUS_ADDR;
                    end else if (!penable) begin
                        penable <= 1'b1;
                    end else if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        if (prdata[sdr_pkg::STAT_READY] && !prdata[sdr_pkg::STAT_BUSY]) begin
                            state <= S_WAIT_HOLD;
                        end
                    end
                end
                S_WAIT_HOLD: begin
                    if (!hold) begin
                        psel  <= 1'b1;
                        paddr <= sdr_pkg::BUF_BASE + {6'b0, count};
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (!penable) begin
                        penable <= 1'b1;
                    end else if (pready) begin
                        psel      <= 1'b0;
                        penable   <= 1'b0;
                        out_valid <= 1'b1;
                        out_index <= count[8:0];
                        out_byte  <= prdata[7:0];
                        count     <= count + 10'd1;
                        state     <= S_EMIT;
                    end
                end
                S_EMIT: begin
                    out_valid <= 1'b0;
                    if (last_byte) begin
                        done  <= 1'b1;
                        state <= S_FINISHED;
                    end else if (!hold) begin
                        // go straight into the next setup phase
                        psel  <= 1'b1;
                        paddr <= sdr_pkg::BUF_BASE + {6'b0, count};
                        state <= S_FETCH;
                    end else begin
                        state <= S_WAIT_HOLD;
                    end
                end
                S_FINISHED: begin
                    done  <= 1'b0;
                    state <= S_REARM;
                end
                S_REARM: begin
                    // start has to drop before another read is accepted
                    if (!start) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rstn)
        penable |-> psel);

    // address set in the setup cycle holds through the whole access phase
    a_paddr_stable: assert property (@(posedge clk) disable iff (!rstn)
        psel && penable |-> $stable(paddr));

endmodule

`default_nettype wire

// File: rtl/word_packer.sv
// gathers sector bytes into little-endian 32-bit words and writes them to RAM
// one word may wait on mem_ready while the next three bytes collect;
// hold stops the reader before a fourth byte would find the word slot still full

`timescale 1ns/1ps
`default_nettype none

module word_packer #(
    parameter int MEM_AW = 16
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire  [MEM_AW-1:0] dest_base,
    input  wire               in_valid,
    input  wire  [8:0]        in_index,
    input  wire  [7:0]        in_byte,
    output logic              hold,
    output logic              mem_valid,
    output logic [MEM_AW-1:0] mem_addr,
    output logic [31:0]       mem_wdata,
    input  wire               mem_ready
);

    // lanes 0 to 2 of the word being built
    logic [23:0] gather;

    // set once lane 2 is in, so the next byte completes a word
    logic        three_in;

    logic [1:0]  lane;

    assign lane = in_index[1:0];

    // also covers the lane 2 byte arriving this very cycle
    assign hold = mem_valid && (three_in || (in_valid && lane == 2'd2));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_valid <= 1'b0;
            three_in  <= 1'b0;
        end else begin
            if (mem_valid && mem_ready) begin
                mem_valid <= 1'b0;
            end
            if (in_valid) begin
                three_in <= (lane == 2'd2);
                if (lane == 2'd3) begin
                    mem_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            case (lane)
                2'd0: gather[7:0]   <= in_byte;
                2'd1: gather[15:8]  <= in_byte;
                2'd2: gather[23:16] <= in_byte;
                default: begin
                    mem_wdata <= {in_byte, gather};
                    mem_addr  <= dest_base + MEM_AW'(in_index[8:2]);
                end
            endcase
        end
    end

    // a presented word stays put until the RAM takes it
    a_word_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_wdata) && $stable(mem_addr));

endmodule

`default_nettype wire

// File: rtl/sd_boot_loader.sv
// boot loader top: copies one SD sector into RAM starting at word dest_base
// pulse start with sector and dest_base; done pulses after the last byte
// dest_base must stay stable from start until the last word is written

`timescale 1ns/1ps
`default_nettype none

module sd_boot_loader #(
    parameter int MEM_AW = 16
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               start,
    input  wire  [31:0]       sector,
    input  wire  [MEM_AW-1:0] dest_base,
    output logic              done,
    output logic              card_req,
    output logic [31:0]       card_sector,
    input  wire               card_valid,
    input  wire  [7:0]        card_data,
    output logic              mem_valid,
    output logic [MEM_AW-1:0] mem_addr,
    output logic [31:0]       mem_wdata,
    input  wire               mem_ready
);

    // APB between reader and controller
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [sdr_pkg::APB_AW-1:0] paddr;
    logic [sdr_pkg::APB_DW-1:0] pwdata;
    logic [sdr_pkg::APB_DW-1:0] prdata;
    logic                       pready;

    // byte stream into the packer
    logic                       out_valid;
    logic [8:0]                 out_index;
    logic [7:0]                 out_byte;
    logic                       hold;

    // sector buffer ports
    logic                       buf_we;
    logic [8:0]                 buf_waddr;
    logic [7:0]                 buf_wdata;
    logic [8:0]                 buf_raddr;
    logic [7:0]                 buf_rdata;

    sector_reader u_reader (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .sector    (sector),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_byte  (out_byte),
        .hold      (hold),
        .done      (done)
    );

    sd_block_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .card_req    (card_req),
        .card_sector (card_sector),
        .card_valid  (card_valid),
        .card_data   (card_data),
        .buf_we      (buf_we),
        .buf_waddr   (buf_waddr),
        .buf_wdata   (buf_wdata),
        .buf_raddr   (buf_raddr),
        .buf_rdata   (buf_rdata)
    );

    sector_buffer u_buffer (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .raddr (buf_raddr),
        .rdata (buf_rdata)
    );

    word_packer #(
        .MEM_AW (MEM_AW)
    ) u_packer (
        .clk       (clk),
        .rstn      (rstn),
        .dest_base (dest_base),
        .in_valid  (out_valid),
        .in_index  (out_index),
        .in_byte   (out_byte),
        .hold      (hold),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

endmodule

`default_nettype wire

// File: sim/sd_card_model.sv
// behavioral SD card on the block-stream port of the boot loader
// answers each card_req after latency cycles with the 512 bytes of the requested sector,
// byte i of sector s being the low byte of s*7+i, with random gaps of 0 to max_gap cycles

`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input  wire        clk,
    input  wire        rstn,
    input  wire        card_req,
    input  wire [31:0] card_sector,
    input  wire [31:0] latency,
    input  wire [31:0] max_gap,
    output logic       card_valid,
    output logic [7:0] card_data
);

    // streams one sector; a reset seen at any clock edge drops the transfer
    task automatic stream_sector(input logic [31:0] s);
        logic [31:0] v;
        int          gap;
        int          i;
        repeat (latency) begin
            @(posedge clk);
            if (!rstn) return;
        end
        for (i = 0; i < sdr_pkg::SECTOR_BYTES; i++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) begin
                #2;
                card_valid = 1'b0;
                @(posedge clk);
                if (!rstn) return;
            end
            v = s * 7 + i;
            #2;
            card_valid = 1'b1;
            card_data  = v[7:0];
            @(posedge clk);
            if (!rstn) return;
        end
    endtask

    initial begin
        card_valid = 1'b0;
        card_data  = 8'h00;
        forever begin
            @(posedge clk);
            if (rstn && card_req) begin
                stream_sector(card_sector);
                #2;
                card_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_sd_boot_loader.sv
// testbench for the SD boot loader
// a behavioral card feeds the controller, a RAM model records accepted word writes,
// and directed tests compare RAM contents with the sector byte pattern

`timescale 1ns/1ps
`default_nettype none

module tb_sd_boot_loader;

    localparam int MEM_AW         = 16;
    localparam int RAM_WORDS      = 1 << MEM_AW;
    localparam int SECTOR_WORDS   = sdr_pkg::SECTOR_BYTES / 4;
    localparam int TIMEOUT_CYCLES = 60000;

    logic              clk;
    logic              rstn;
    logic              start;
    logic [31:0]       sector;
    logic [MEM_AW-1:0] dest_base;
    logic              done;
    logic              card_req;
    logic [31:0]       card_sector;
    logic              card_valid;
    logic [7:0]        card_data;
    logic              mem_valid;
    logic [MEM_AW-1:0] mem_addr;
    logic [31:0]       mem_wdata;
    logic              mem_ready;

    logic [31:0] card_latency;
    logic [31:0] card_max_gap;
    int          stall_pct;

    logic [31:0] ram [0:RAM_WORDS-1];
    int          hits [0:RAM_WORDS-1];
    int          write_total;
    int          done_count;
    int          req_count;
    logic [31:0] last_req_sector;
    int          cycle_count;
    int          checks;
    int          errors;
    string       cur_test;

    sd_boot_loader #(
        .MEM_AW (MEM_AW)
    ) DUT (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .sector      (sector),
        .dest_base   (dest_base),
        .done        (done),
        .card_req    (card_req),
        .card_sector (card_sector),
        .card_valid  (card_valid),
        .card_data   (card_data),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready)
    );

    sd_card_model u_card (
        .clk         (clk),
        .rstn        (rstn),
        .card_req    (card_req),
        .card_sector (card_sector),
        .latency     (card_latency),
        .max_gap     (card_max_gap),
        .card_valid  (card_valid),
        .card_data   (card_data)
    );

    always #20 clk = ~clk;

    // RAM accepts a word with probability 100 - stall_pct percent
    always @(posedge clk) begin
        #2;
        mem_ready = ($urandom_range(99, 0) >= stall_pct);
    end

    // RAM model and event counters
    always @(posedge clk) begin
        if (rstn && mem_valid && mem_ready) begin
            ram[mem_addr] = mem_wdata;
            hits[mem_addr]++;
            write_total++;
        end
        if (rstn && done) begin
            done_count++;
        end
        if (rstn && card_req) begin
            req_count++;
            last_req_sector = card_sector;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // untouched RAM words hold a value tied to their address
    function automatic logic [31:0] fill_word(input int a);
        logic [15:0] a16;
        a16 = a[15:0];
        return {a16 ^ 16'h5a5a, ~a16};
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [31:0] s, input int i);
        logic [31:0] v;
        v = s * 7 + i;
        return v[7:0];
    endfunction

    // little-endian word k of sector s
    function automatic logic [31:0] expected_word(input logic [31:0] s, input int k);
        logic [31:0] w;
        int          b;
        for (b = 0; b < 4; b++) begin
            w[8*b +: 8] = pattern_byte(s, 4 * k + b);
        end
        return w;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    // every word of the region carries the pattern and was written exactly once
    task automatic check_region(input logic [31:0] s, input int base);
        int k;
        for (k = 0; k < SECTOR_WORDS; k++) begin
            compare_value($sformatf("data at %0d", base + k), expected_word(s, k),
                          ram[base + k]);
            compare_value($sformatf("writes to %0d", base + k), 1, hits[base + k]);
        end
    endtask

    task automatic pulse_start(input logic [31:0] s, input int base);
        @(posedge clk);
        #2;
        start     = 1'b1;
        sector    = s;
        dest_base = base[MEM_AW-1:0];
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        // last word may still be waiting on the RAM
        while (mem_valid) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic load_sector(input logic [31:0] s, input int base);
        pulse_start(s, base);
        wait_done();
    endtask

    task automatic test_single_sector();
        int d0;
        int w0;
        cur_test = "test_single_sector";
        d0 = done_count;
        w0 = write_total;
        load_sector(3, 0);
        check_region(3, 0);
        compare_value("done pulses", 1, done_count - d0);
        compare_value("word writes", SECTOR_WORDS, write_total - w0);
    endtask

    task automatic test_back_to_back();
        cur_test = "test_back_to_back";
        load_sector(10, 256);
        load_sector(11, 384);
        check_region(10, 256);
        check_region(11, 384);
        compare_value("word past region", fill_word(512), ram[512]);
    endtask

    task automatic test_ram_backpressure();
        cur_test  = "test_ram_backpressure";
        stall_pct = 50;
        load_sector(42, 128);
        stall_pct = 0;
        check_region(42, 128);
    endtask

    task automatic test_slow_card();
        int r0;
        cur_test     = "test_slow_card";
        card_latency = 60;
        card_max_gap = 20;
        r0           = req_count;
        load_sector(7, 512);
        card_latency = 4;
        card_max_gap = 0;
        compare_value("card requests", 1, req_count - r0);
        compare_value("card sector", 7, last_req_sector);
        check_region(7, 512);
    endtask

    task automatic test_start_held();
        int r0;
        cur_test = "test_start_held";
        r0       = req_count;
        @(posedge clk);
        #2;
        start     = 1'b1;
        sector    = 20;
        dest_base = 640;
        wait_done();
        repeat (100) @(negedge clk);
        compare_value("card requests with start held", 1, req_count - r0);
        check_region(20, 640);
        // start low for one cycle rearms the reader
        @(posedge clk);
        #2;
        start = 1'b0;
        load_sector(21, 768);
        compare_value("card requests after rearm", 2, req_count - r0);
        check_region(21, 768);
    endtask

    task automatic test_reset_midread();
        int w0;
        cur_test = "test_reset_midread";
        w0       = write_total;
        pulse_start(9, 1024);
        while (write_total < w0 + SECTOR_WORDS / 2) begin
            @(negedge clk);
        end
        // stall the RAM so a word is still pending when reset hits
        stall_pct = 100;
        while (!(mem_valid && !mem_ready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        rstn = 1'b0;
        repeat (3) begin
            @(negedge clk);
            compare_value("done in reset", 0, done);
            compare_value("mem_valid in reset", 0, mem_valid);
            compare_value("card_req in reset", 0, card_req);
        end
        stall_pct = 0;
        @(posedge clk);
        #2;
        rstn = 1'b1;
        load_sector(5, 1152);
        check_region(5, 1152);
    endtask

    initial begin
        void'($urandom(32'hcfd5_90f3));
        clk          = 1'b0;
        rstn         = 1'b0;
        start        = 1'b0;
        sector       = '0;
        dest_base    = '0;
        mem_ready    = 1'b1;
        card_latency = 4;
        card_max_gap = 0;
        stall_pct    = 0;
        write_total  = 0;
        done_count   = 0;
        req_count    = 0;
        checks       = 0;
        errors       = 0;
        for (int a = 0; a < RAM_WORDS; a++) begin
            ram[a]  = fill_word(a);
            hits[a] = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;

        test_single_sector();
        test_back_to_back();
        test_ram_backpressure();
        test_slow_card();
        test_start_held();
        test_reset_midread();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/sdr_pkg.sv
rtl/sector_buffer.sv
rtl/sd_block_ctrl.sv
rtl/sector_reader.sv
rtl/word_packer.sv
rtl/sd_boot_loader.sv
sim/sd_card_model.sv
sim/tb_sd_boot_loader.sv

// File: Bender.yml
package:
  name: sd_boot_loader

sources:
  - rtl/sdr_pkg.sv
  - rtl/sector_buffer.sv
  - rtl/sd_block_ctrl.sv
  - rtl/sector_reader.sv
  - rtl/word_packer.sv
  - rtl/sd_boot_loader.sv
  - target: simulation
    files:
      - sim/sd_card_model.sv
      - sim/tb_sd_boot_loader.sv
